// File: logic/eth_tx_ifs.sv
`timescale 1ns/1ns

// Steering block to one frame buffer
interface buf_wr_if import eth_tx_pkg::*; ();

  byte_t      dat;
  logic       val;
  logic       last;
  mac_addr_t  dst;
  ethertype_t etype;
  logic       credit; // One frame slot handed back

  modport steer (
    output dat, val, last, dst, etype,
    input  credit
  );

  modport buffer (
    input  dat, val, last, dst, etype,
    output credit
  );

endinterface

// Frame source (buffer or mux) to frame sink (mux or framer)
interface mac_tx_if import eth_tx_pkg::*; ();

  mac_addr_t  dst;
  ethertype_t etype;
  len_t       len;
  logic       rdy;      // Complete frame held, metadata valid
  logic       req;      // Payload byte wanted next cycle
  logic       acc;      // Metadata taken
  byte_t      strm_dat;
  logic       strm_val;
  logic       done;     // Last FCS byte is out

  modport source (
    output dst, etype, len, rdy, strm_dat, strm_val,
    input  req, acc, done
  );

  modport sink (
    input  dst, etype, len, rdy, strm_dat, strm_val,
    output req, acc, done
  );

endinterface

// File: logic/eth_tx_mux.sv
`timescale 1ns/1ns

module eth_tx_mux import eth_tx_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  mac_tx_if.sink   src [N_CHAN],
  mac_tx_if.source snk
);

  mux_state_t        state;
  chan_t             ptr;     // Highest priority next round
  chan_t             grant;
  chan_t             pick;
  logic              any_rdy;
  logic [N_CHAN-1:0] gnt;     // One-hot while BUSY
  logic [N_CHAN-1:0] rdy_v;
  logic [N_CHAN-1:0] sval_v;
  mac_addr_t         dst_v [N_CHAN];
  ethertype_t        etype_v [N_CHAN];
  len_t              len_v [N_CHAN];
  byte_t             dat_v [N_CHAN];

  // Round-robin search, lowest offset from ptr wins
  always_comb begin
    int idx;
    any_rdy = 1'b0;
    pick    = ptr;
    for (int k = N_CHAN - 1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % N_CHAN;
      if (rdy_v[idx]) begin
        pick    = chan_t'(idx);
        any_rdy = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SELECT;
      ptr   <= '0;
      grant <= '0;
    end else begin
      case (state)
        SELECT: if (any_rdy) begin
          grant <= pick;
          state <= BUSY;
        end
        BUSY: if (snk.done) begin
          state <= SELECT;
          ptr   <= (grant == chan_t'(N_CHAN - 1)) ? '0 : grant + 1'b1;
        end
        default: state <= SELECT;
      endcase
    end
  end

  assign gnt = (state == BUSY) ? (N_CHAN'(1) << grant) : '0;

  for (genvar i = 0; i < N_CHAN; i++) begin : g_port
    assign rdy_v[i]   = src[i].rdy;
    assign sval_v[i]  = src[i].strm_val;
    assign dst_v[i]   = src[i].dst;
    assign etype_v[i] = src[i].etype;
    assign len_v[i]   = src[i].len;
    assign dat_v[i]   = src[i].strm_dat;
    assign src[i].acc  = gnt[i] && snk.acc;  // Losers see nothing
    assign src[i].req  = gnt[i] && snk.req;
    assign src[i].done = gnt[i] && snk.done;
  end

  assign snk.rdy      = (state == BUSY) && rdy_v[grant];
  assign snk.dst      = dst_v[grant];
  assign snk.etype    = etype_v[grant];
  assign snk.len      = len_v[grant];
  assign snk.strm_dat = dat_v[grant];
  assign snk.strm_val = (state == BUSY) && sval_v[grant];

endmodule

// File: logic/eth_tx_pkg.sv
package eth_tx_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////
  localparam int N_CHAN      = 2;
  localparam int BUF_FRAMES  = 2;     // Slots per buffer, also initial credits
  localparam int MAX_PAYLOAD = 1500;
  localparam int MIN_PAYLOAD = 46;    // 60-byte frame before FCS
  localparam int IFG_BYTES   = 12;

  localparam int CHAN_W   = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;
  localparam int SLOT_W   = (BUF_FRAMES > 1) ? $clog2(BUF_FRAMES) : 1;
  localparam int CREDIT_W = $clog2(BUF_FRAMES + 1);
  localparam int MEM_DEPTH = BUF_FRAMES * MAX_PAYLOAD;
  localparam int ADDR_W    = $clog2(MEM_DEPTH);

  typedef logic [7:0]          byte_t;
  typedef logic [47:0]         mac_addr_t;
  typedef logic [15:0]         ethertype_t;
  typedef logic [CHAN_W-1:0]   chan_t;
  typedef logic [10:0]         len_t;
  typedef logic [31:0]         crc_t;
  typedef logic [CREDIT_W-1:0] credit_t;
  typedef logic [SLOT_W-1:0]   slot_t;
  typedef logic [ADDR_W-1:0]   addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Frame format
  ////////////////////////////////////////////////////////////////////////////
  localparam mac_addr_t DEV_MAC = 48'h02_1a_c4_70_3e_05; // Locally administered

  localparam int PREAMBLE_BYTES = 7;
  localparam int HDR_BYTES      = 14; // dst + src + EtherType
  localparam int FCS_BYTES      = 4;

  localparam byte_t PREAMBLE_BYTE = 8'h55;
  localparam byte_t SFD_BYTE      = 8'hd5;
  localparam crc_t  CRC_POLY      = 32'hedb88320; // Reflected 802.3 polynomial

  typedef enum logic [2:0] {
    IDLE, PREAMBLE, HEADER, PAYLOAD, PAD, FCS, GAP
  } framer_state_t;

  typedef enum logic {
    SELECT, BUSY
  } mux_state_t;

endpackage

// File: logic/eth_tx_top.sv
`timescale 1ns/1ns

module eth_tx_top import eth_tx_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // User frame stream
  input  byte_t      tx_dat,
  input  logic       tx_val,
  input  logic       tx_last,
  input  chan_t      tx_chan,   // Sampled with the first byte
  input  mac_addr_t  tx_dst,
  input  ethertype_t tx_etype,
  output logic       tx_cts,
  // GMII-style byte output
  output byte_t      gmii_dat,
  output logic       gmii_val
);

  buf_wr_if wr_if [N_CHAN] ();
  mac_tx_if buf_if [N_CHAN] ();
  mac_tx_if fr_if ();

  tx_steer u_steer (
    .clk      (clk),
    .rst      (rst),
    .tx_dat   (tx_dat),
    .tx_val   (tx_val),
    .tx_last  (tx_last),
    .tx_chan  (tx_chan),
    .tx_dst   (tx_dst),
    .tx_etype (tx_etype),
    .tx_cts   (tx_cts),
    .wr       (wr_if)
  );

  ////////////////////////////////////////////////////////////////////////////
  // One frame buffer per channel
  ////////////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < N_CHAN; i++) begin : g_buf
    tx_frame_buf #(
      .CHAN_ID (i)
    ) u_buf (
      .clk (clk),
      .rst (rst),
      .wr  (wr_if[i]),
      .src (buf_if[i])
    );
  end

  eth_tx_mux u_mux (
    .clk (clk),
    .rst (rst),
    .src (buf_if),
    .snk (fr_if)
  );

  mac_tx_framer u_framer (
    .clk      (clk),
    .rst      (rst),
    .snk      (fr_if),
    .gmii_dat (gmii_dat),
    .gmii_val (gmii_val)
  );

endmodule

// File: logic/mac_tx_framer.sv
`timescale 1ns/1ns

module mac_tx_framer import eth_tx_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  mac_tx_if.sink snk,
  output byte_t  gmii_dat,
  output logic   gmii_val
);

  framer_state_t          state;
  len_t                   cnt;      // Byte index inside the current state
  mac_addr_t              dst_q;
  ethertype_t             etype_q;
  len_t                   len_q;
  crc_t                   crc;
  crc_t                   fcs;
  logic [HDR_BYTES*8-1:0] hdr;

  // One byte of the reflected CRC-32, LSB first
  function automatic crc_t crc_next(crc_t c, byte_t d);
    crc_t r;
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
    end
    return r;
  endfunction

  assign hdr = {dst_q, DEV_MAC, etype_q};
  assign fcs = ~crc;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake with the frame source
  ////////////////////////////////////////////////////////////////////////////
  assign snk.acc  = (state == IDLE) && snk.rdy;
  // Asked one cycle ahead, so the last header byte already requests
  assign snk.req  = ((state == HEADER) && (cnt == len_t'(HDR_BYTES - 1))) ||
                    ((state == PAYLOAD) && (cnt < len_q - 1'b1));
  assign snk.done = (state == GAP) && (cnt == '0);

  always_ff @(posedge clk) begin
    if (snk.acc) begin
      dst_q   <= snk.dst;
      etype_q <= snk.etype;
      len_q   <= snk.len;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte output
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (state)
      PREAMBLE: gmii_dat = (cnt == len_t'(PREAMBLE_BYTES)) ? SFD_BYTE : PREAMBLE_BYTE;
      HEADER:   gmii_dat = hdr[8 * (HDR_BYTES - 1 - cnt) +: 8]; // dst high byte first
      PAYLOAD:  gmii_dat = snk.strm_val ? snk.strm_dat : 8'h00;
      FCS:      gmii_dat = fcs[8 * cnt[1:0] +: 8];             // Low byte first
      default:  gmii_dat = 8'h00;                              // Pad and idle
    endcase
  end

  assign gmii_val = state inside {PREAMBLE, HEADER, PAYLOAD, PAD, FCS};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      cnt   <= '0;
      crc   <= '1;
    end else begin
      cnt <= cnt + 1'b1;
      if (state inside {HEADER, PAYLOAD, PAD})
        crc <= crc_next(crc, gmii_dat);

      case (state)
        IDLE: begin
          cnt <= '0;
          if (snk.rdy) begin
            state <= PREAMBLE;
            crc   <= '1;
          end
        end
        PREAMBLE: if (cnt == len_t'(PREAMBLE_BYTES)) begin // SFD is byte 7
          state <= HEADER;
          cnt   <= '0;
        end
        HEADER: if (cnt == len_t'(HDR_BYTES - 1)) begin
          state <= PAYLOAD;
          cnt   <= '0;
        end
        PAYLOAD: if (cnt == len_q - 1'b1) begin
          if (len_q < len_t'(MIN_PAYLOAD)) begin
            state <= PAD;                               // cnt runs on into the pad
          end else begin
            state <= FCS;
            cnt   <= '0;
          end
        end
        PAD: if (cnt == len_t'(MIN_PAYLOAD - 1)) begin
          state <= FCS;
          cnt   <= '0;
        end
        FCS: if (cnt == len_t'(FCS_BYTES - 1)) begin
          state <= GAP;
          cnt   <= '0;
        end
        // Accept cycle in IDLE is the last idle byte of the gap
        GAP: if (cnt == len_t'(IFG_BYTES - 2)) begin
          state <= IDLE;
          cnt   <= '0;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: logic/tx_frame_buf.sv
`timescale 1ns/1ns

module tx_frame_buf import eth_tx_pkg::*; #(
  parameter int CHAN_ID = 0
) (
  input  logic      clk,
  input  logic      rst,
  buf_wr_if.buffer  wr,
  mac_tx_if.source  src
);

  byte_t                 mem [MEM_DEPTH];
  len_t                  len_mem [BUF_FRAMES];
  mac_addr_t             dst_mem [BUF_FRAMES];
  ethertype_t            etype_mem [BUF_FRAMES];
  logic [BUF_FRAMES-1:0] full;        // Slot holds a complete frame
  slot_t                 wr_slot;
  slot_t                 rd_slot;
  len_t                  wr_cnt;
  len_t                  rd_cnt;
  addr_t                 wr_addr;
  addr_t                 rd_addr;
  logic                  wr_room;
  byte_t                 rd_q;
  logic                  rd_val_q;
  logic                  credit_q;

  if (CHAN_ID < 0 || CHAN_ID >= N_CHAN) begin : g_bad_chan
    $error("tx_frame_buf: CHAN_ID %0d outside 0..%0d", CHAN_ID, N_CHAN - 1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////////////////////
  assign wr_room = wr_cnt < len_t'(MAX_PAYLOAD); // Bytes past the limit are lost
  assign wr_addr = addr_t'(wr_slot) * addr_t'(MAX_PAYLOAD) + addr_t'(wr_cnt);
  assign rd_addr = addr_t'(rd_slot) * addr_t'(MAX_PAYLOAD) + addr_t'(rd_cnt);

  always_ff @(posedge clk) begin
    if (wr.val && wr_room)
      mem[wr_addr] <= wr.dat;
    if (src.req)
      rd_q <= mem[rd_addr];
  end

  // Metadata stored with the last byte
  always_ff @(posedge clk) begin
    if (wr.val && wr.last) begin
      len_mem[wr_slot]   <= wr_cnt + len_t'(wr_room);
      dst_mem[wr_slot]   <= wr.dst;
      etype_mem[wr_slot] <= wr.etype;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Slot control
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      full     <= '0;
      wr_slot  <= '0;
      rd_slot  <= '0;
      wr_cnt   <= '0;
      rd_cnt   <= '0;
      rd_val_q <= 1'b0;
      credit_q <= 1'b0;
    end else begin
      rd_val_q <= src.req;
      credit_q <= src.done;

      if (wr.val) begin
        if (wr.last) begin
          full[wr_slot] <= 1'b1;
          wr_slot       <= (wr_slot == slot_t'(BUF_FRAMES - 1)) ? '0 : wr_slot + 1'b1;
          wr_cnt        <= '0;
        end else if (wr_room) begin
          wr_cnt <= wr_cnt + 1'b1;
        end
      end

      if (src.acc)
        rd_cnt <= '0;
      else if (src.req)
        rd_cnt <= rd_cnt + 1'b1;

      // Sink is finished, free the slot and move to the next one
      if (src.done) begin
        full[rd_slot] <= 1'b0;
        rd_slot       <= (rd_slot == slot_t'(BUF_FRAMES - 1)) ? '0 : rd_slot + 1'b1;
      end
    end
  end

  assign src.rdy      = full[rd_slot];
  assign src.len      = len_mem[rd_slot];
  assign src.dst      = dst_mem[rd_slot];
  assign src.etype    = etype_mem[rd_slot];
  assign src.strm_dat = rd_q;
  assign src.strm_val = rd_val_q;
  assign wr.credit    = credit_q;

endmodule

// File: logic/tx_steer.sv
`timescale 1ns/1ns

module tx_steer import eth_tx_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  byte_t      tx_dat,
  input  logic       tx_val,
  input  logic       tx_last,
  input  chan_t      tx_chan,
  input  mac_addr_t  tx_dst,
  input  ethertype_t tx_etype,
  output logic       tx_cts,
  buf_wr_if.steer    wr [N_CHAN]
);

  credit_t             cred_cnt [N_CHAN];
  logic                in_frame;
  chan_t               cur_chan;
  chan_t               sel_chan;
  logic                accept;
  logic                first;
  logic [N_CHAN-1:0]   take;
  logic [N_CHAN-1:0]   val_q;
  byte_t               dat_q;
  logic                last_q;
  mac_addr_t           dst_q;
  ethertype_t          etype_q;

  // Channel is locked for the rest of a frame
  assign sel_chan = in_frame ? cur_chan : tx_chan;
  assign tx_cts   = in_frame || (cred_cnt[tx_chan] != '0);
  assign accept   = tx_val && tx_cts;
  assign first    = accept && !in_frame;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame <= 1'b0;
      cur_chan <= '0;
      val_q    <= '0;
    end else begin
      val_q <= '0;
      if (accept) begin
        val_q[sel_chan] <= 1'b1;
        in_frame        <= !tx_last;
      end
      if (first)
        cur_chan <= tx_chan;
    end
  end

  // Byte and first-byte metadata, one cycle to the buffer
  always_ff @(posedge clk) begin
    if (accept) begin
      dat_q  <= tx_dat;
      last_q <= tx_last;
    end
    if (first) begin
      dst_q   <= tx_dst;
      etype_q <= tx_etype;
    end
  end

  for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
    assign take[i] = first && (tx_chan == chan_t'(i));

    // Take and return may land in the same cycle
    always_ff @(posedge clk) begin
      if (rst)
        cred_cnt[i] <= credit_t'(BUF_FRAMES);
      else
        cred_cnt[i] <= cred_cnt[i] - credit_t'(take[i]) + credit_t'(wr[i].credit);
    end

    assign wr[i].dat   = dat_q;
    assign wr[i].val   = val_q[i];
    assign wr[i].last  = last_q;
    assign wr[i].dst   = dst_q;
    assign wr[i].etype = etype_q;
  end

endmodule

// File: project.f
logic/eth_tx_pkg.sv
logic/eth_tx_ifs.sv
logic/tx_steer.sv
logic/tx_frame_buf.sv
logic/eth_tx_mux.sv
logic/mac_tx_framer.sv
logic/eth_tx_top.sv
tests/eth_tx_assert.sv
tests/eth_tx_tb.sv

// File: tests/eth_tx_assert.sv
`timescale 1ns/1ns

module eth_tx_assert import eth_tx_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  mux_state_t        state,
  input  chan_t             grant,
  input  logic [N_CHAN-1:0] gnt,
  input  logic [N_CHAN-1:0] rdy_v,
  input  logic [N_CHAN-1:0] sval_v,
  input  logic              acc,
  input  logic              done
);

  int fail_cnt;

  initial fail_cnt = 0;

  // Only the granted buffer may stream to the framer
  a_one_grant: assert property (@(posedge clk) disable iff (rst)
      (sval_v & ~gnt) == '0)
    else begin
      $error("Stream from a buffer without grant: strm_val %b, grant %b", sval_v, gnt);
      fail_cnt++;
    end

  a_acc_rdy: assert property (@(posedge clk) disable iff (rst)
      acc |-> (state == BUSY) && rdy_v[grant])
    else begin
      $error("acc without rdy on granted channel %0d", grant);
      fail_cnt++;
    end

  a_done_busy: assert property (@(posedge clk) disable iff (rst) done |-> state == BUSY)
    else begin
      $error("done outside BUSY");
      fail_cnt++;
    end

endmodule

bind eth_tx_mux eth_tx_assert u_assert (
  .clk    (clk),
  .rst    (rst),
  .state  (state),
  .grant  (grant),
  .gnt    (gnt),
  .rdy_v  (rdy_v),
  .sval_v (sval_v),
  .acc    (snk.acc),
  .done   (snk.done)
);

// File: tests/eth_tx_tb.sv
`timescale 1ns/1ns

module eth_tx_tb import eth_tx_pkg::*; ();

  localparam int FRAME_TIMEOUT = 4000; // Cycles to wait for frames on gmii
  localparam int CTS_TIMEOUT   = 2000;

  logic       clk;
  logic       rst;
  byte_t      tx_dat;
  logic       tx_val;
  logic       tx_last;
  chan_t      tx_chan;
  mac_addr_t  tx_dst;
  ethertype_t tx_etype;
  logic       tx_cts;
  byte_t      gmii_dat;
  logic       gmii_val;

  integer     seed;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  logic       timed_out = 1'b0;
  logic       cts_low_seen = 1'b0;

  // Expected frames back to back with length and channel per frame
  byte_t      exp_bytes [$];
  int         exp_len [$];
  int         exp_chan [$];
  // Captured frames and the idle run before each one
  byte_t      cap_bytes [$];
  int         cap_len [$];
  int         cap_gap [$];
  logic       mon_in_frame = 1'b0;
  int         mon_len = 0;
  int         mon_low = 0;
  int         mon_gap = 0;

  eth_tx_top dut (
    .clk      (clk),
    .rst      (rst),
    .tx_dat   (tx_dat),
    .tx_val   (tx_val),
    .tx_last  (tx_last),
    .tx_chan  (tx_chan),
    .tx_dst   (tx_dst),
    .tx_etype (tx_etype),
    .tx_cts   (tx_cts),
    .gmii_dat (gmii_dat),
    .gmii_val (gmii_val)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Frame capture sampled mid-cycle
  always @(negedge clk) begin
    if (gmii_val === 1'b1) begin
      if (!mon_in_frame) begin
        mon_len = 0;
        mon_gap = mon_low;
      end
      cap_bytes.push_back(gmii_dat);
      mon_len++;
      mon_in_frame = 1'b1;
    end else begin
      if (mon_in_frame) begin
        cap_len.push_back(mon_len);
        cap_gap.push_back(mon_gap);
        mon_low = 0;
      end
      mon_in_frame = 1'b0;
      mon_low++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic crc_t crc_update(crc_t c, byte_t b);
    crc_t r;
    logic fb;
    r = c;
    for (int i = 0; i < 8; i++) begin // Bit by bit with LSB first
      fb = r[0] ^ b[i];
      r  = r >> 1;
      if (fb)
        r = r ^ 32'hedb88320;
    end
    return r;
  endfunction

  function automatic mac_addr_t chan_dst(int c);
    return 48'h0a_12_34_56_78_00 + mac_addr_t'(c);
  endfunction

  function automatic ethertype_t chan_etype(int c);
    return 16'h88b5 + ethertype_t'(c);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checking
  ////////////////////////////////////////////////////////////////////////////
  task automatic send_frame(input int c, input int len);
    byte_t      pay [$];
    byte_t      fr [$];
    crc_t       crc;
    mac_addr_t  dst;
    ethertype_t etype;
    int         waited;
    if (timed_out)
      return;
    dst   = chan_dst(c);
    etype = chan_etype(c);
    repeat (len) pay.push_back(byte_t'($random(seed)));
    repeat (7) fr.push_back(8'h55);
    fr.push_back(8'hd5);                                  // SFD
    for (int i = 5; i >= 0; i--) fr.push_back(dst[8*i +: 8]);
    for (int i = 5; i >= 0; i--) fr.push_back(DEV_MAC[8*i +: 8]);
    fr.push_back(etype[15:8]);
    fr.push_back(etype[7:0]);
    for (int i = 0; i < len && i < MAX_PAYLOAD; i++) fr.push_back(pay[i]);
    while (fr.size() < 8 + 14 + MIN_PAYLOAD) fr.push_back(8'h00);
    crc = '1;
    for (int i = 8; i < fr.size(); i++) crc = crc_update(crc, fr[i]);
    crc = ~crc;
    for (int i = 0; i < 4; i++) fr.push_back(crc[8*i +: 8]); // FCS low byte first
    foreach (fr[k]) exp_bytes.push_back(fr[k]);
    exp_len.push_back(fr.size());
    exp_chan.push_back(c);

    for (int i = 0; i < len; i++) begin
      tx_val   = 1'b1;
      tx_dat   = pay[i];
      tx_last  = (i == len - 1);
      tx_chan  = chan_t'(c);
      tx_dst   = dst;
      tx_etype = etype;
      waited   = 0;
      @(negedge clk);
      while (!tx_cts && waited < CTS_TIMEOUT) begin
        cts_low_seen = 1'b1;
        waited++;
        @(negedge clk);
      end
      if (!tx_cts) begin
        $display("Timeout: tx_cts stayed low for %0d cycles on channel %0d", waited, c);
        errors++;
        timed_out = 1'b1;
        tx_val    = 1'b0;
        return;
      end
      @(posedge clk);
      #10;
    end
    tx_val  = 1'b0;
    tx_last = 1'b0;
  endtask

  task automatic wait_frames(input int n);
    int cyc;
    cyc = 0;
    @(posedge clk);
    while (cap_len.size() < n && cyc < FRAME_TIMEOUT) begin
      @(posedge clk);
      cyc++;
    end
    #10;
    if (cap_len.size() < n) begin
      $display("Timeout: only %0d of %0d frames came out on gmii", cap_len.size(), n);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // Pops one captured frame and matches it with the oldest expected frame of its channel
  task automatic check_frame(output int ch, output int gap, output int flen);
    byte_t     fr [$];
    mac_addr_t d;
    int        idx;
    int        off;
    int        el;
    logic      bad;
    ch   = -1;
    gap  = 0;
    flen = 0;
    if (cap_len.size() == 0) begin
      $display("No captured frame left to check at %0t", $time);
      errors++;
      return;
    end
    flen = cap_len.pop_front();
    gap  = cap_gap.pop_front();
    repeat (flen) fr.push_back(cap_bytes.pop_front());
    d = '0;
    for (int i = 0; i < 6 && flen >= 14; i++) d = {d[39:0], fr[8 + i]};
    for (int c = 0; c < N_CHAN; c++)
      if (d == chan_dst(c)) ch = c;
    idx = -1;
    off = 0;
    for (int i = 0; i < exp_len.size() && idx < 0; i++) begin
      if (exp_chan[i] == ch)
        idx = i;
      else
        off += exp_len[i];
    end
    if (ch < 0 || idx < 0) begin
      $display("Frame with destination %h was not expected at %0t", d, $time);
      errors++;
      return;
    end
    el  = exp_len[idx];
    bad = 1'b0;
    if (flen != el) begin
      $display("ERROR at %0t: gmii_val run is %0d cycles, expected %0d", $time, flen, el);
      errors++;
    end
    for (int k = 0; k < flen && k < el && !bad; k++) begin
      if (fr[k] !== exp_bytes[off + k]) begin // First mismatch only
        $display("ERROR at %0t: gmii_dat byte %0d is %h, expected %h",
                 $time, k, fr[k], exp_bytes[off + k]);
        errors++;
        bad = 1'b1;
      end
    end
    repeat (el) exp_bytes.delete(off);
    exp_len.delete(idx);
    exp_chan.delete(idx);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors != errors_before)
      tests_failed++;
    $display("Test %s: %s", name, (errors == errors_before) ? "ok" : "FAILED");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic short_frame_test();
    int ch, gap, flen, e0;
    e0 = errors;
    send_frame(0, 10);
    wait_frames(1);
    if (!timed_out) begin
      check_frame(ch, gap, flen);
      if (flen != 72) begin // Padded to 60 bytes plus preamble and FCS
        $display("ERROR at %0t: gmii_val run is %0d cycles, expected 72", $time, flen);
        errors++;
      end
    end
    report_test("short frame", e0);
  endtask

  task automatic long_frame_test();
    int ch, gap, flen, e0;
    e0 = errors;
    send_frame(1, 300);
    wait_frames(1);
    if (!timed_out) begin
      check_frame(ch, gap, flen);
      if (ch != 1) begin
        $display("ERROR at %0t: gmii_dat destination is channel %0d, expected 1",
                 $time, ch);
        errors++;
      end
      if (flen != 8 + 14 + 300 + 4) begin
        $display("ERROR at %0t: gmii_val run is %0d cycles, expected 326", $time, flen);
        errors++;
      end
    end
    report_test("long frame", e0);
  endtask

  task automatic credit_stall_test();
    int ch, gap, flen, e0;
    e0 = errors;
    for (int i = 0; i < BUF_FRAMES; i++) send_frame(0, 60);
    cts_low_seen = 1'b0;
    send_frame(0, 60);                            // Needs a returned credit
    if (!timed_out && !cts_low_seen) begin
      $display("tx_cts never went low with all buffer slots of channel 0 in use");
      errors++;
    end
    wait_frames(BUF_FRAMES + 1);
    for (int i = 0; i < BUF_FRAMES + 1 && !timed_out; i++)
      check_frame(ch, gap, flen);
    report_test("credit back-pressure", e0);
  endtask

  task automatic round_robin_test();
    int ch, gap, flen, e0;
    int order [4] = '{0, 1, 0, 1}; // Pointer moves past each winner
    e0 = errors;
    send_frame(0, 16);
    send_frame(0, 16);
    send_frame(1, 16);
    send_frame(1, 16);
    wait_frames(4);
    for (int i = 0; i < 4 && !timed_out; i++) begin
      check_frame(ch, gap, flen);
      if (ch != order[i]) begin
        $display("ERROR at %0t: gmii_dat destination of frame %0d is channel %0d, expected %0d",
                 $time, i, ch, order[i]);
        errors++;
      end
    end
    report_test("round-robin order", e0);
  endtask

  task automatic gap_truncation_test();
    int ch, gap, flen, e0;
    e0 = errors;
    send_frame(0, 1510);
    send_frame(1, 20);     // Queued behind the long frame
    wait_frames(2);
    if (!timed_out) begin
      check_frame(ch, gap, flen);
      if (flen != 8 + 14 + MAX_PAYLOAD + 4) begin
        $display("ERROR at %0t: gmii_val run is %0d cycles, expected %0d",
                 $time, flen, 8 + 14 + MAX_PAYLOAD + 4);
        errors++;
      end
      check_frame(ch, gap, flen);
      if (gap != IFG_BYTES) begin
        $display("ERROR at %0t: gmii_val low gap is %0d cycles, expected %0d",
                 $time, gap, IFG_BYTES);
        errors++;
      end
    end
    report_test("gap and truncation", e0);
  endtask

  initial begin
    seed     = 32'hd76bcb9d;
    rst      = 1'b1;
    tx_dat   = '0;
    tx_val   = 1'b0;
    tx_last  = 1'b0;
    tx_chan  = '0;
    tx_dst   = '0;
    tx_etype = '0;
    repeat (5) @(posedge clk);
    #10;
    rst = 1'b0;
    @(negedge clk);
    if (tx_cts !== 1'b1 || gmii_val !== 1'b0) begin
      $display("ERROR at %0t: tx_cts/gmii_val after reset are %b/%b, expected 1/0",
               $time, tx_cts, gmii_val);
      errors++;
    end
    @(posedge clk);
    #10;

    short_frame_test();
    if (!timed_out) long_frame_test();
    if (!timed_out) credit_stall_test();
    if (!timed_out) round_robin_test();
    if (!timed_out) gap_truncation_test();

    if (!timed_out && (cap_len.size() != 0 || exp_len.size() != 0)) begin
      $display("Frames left over: %0d captured, %0d expected", cap_len.size(), exp_len.size());
      errors++;
    end
    if (dut.u_mux.u_assert.fail_cnt != 0) begin
      $display("Handshake assertions failed %0d times", dut.u_mux.u_assert.fail_cnt);
      errors += dut.u_mux.u_assert.fail_cnt;
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule
